//--- hdl/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data path width and register file depth
`define RV_XLEN      32
`define RV_REG_COUNT 32

// addi x0, x0, 0
`define RV_BUBBLE    32'h0000_0013

// mret reads mstatus and flips MPIE/MIE
`define RV_MRET_CSR  12'h300
`define RV_MRET_MASK 32'h0000_0088

`endif

//--- hdl/rv_pkg.sv
package rv_pkg;

  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_xor, alu_or, alu_and, alu_srl, alu_sra, alu_sll,
    alu_slt, alu_sltu, alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu,
    alu_bit_c, alu_ill
  } alu_cmd_e;

  typedef enum logic [2:0] {
    wb_none, ri_type_lui, load, jump, zicsr, wb_mret
  } wb_sel_e;

  typedef enum logic [1:0] {
    pc_next, pc_branch, pc_mret
  } pc_sel_e;

  typedef enum logic [3:0] {
    mem_none, lb, lh, lw, lbu, lhu, sb, sh, sw
  } mem_access_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // one instruction word seen raw for matching and as format views for fields
  typedef union packed {
    logic [31:0] raw;
    r_fmt_t      r_fmt;
    i_fmt_t      i_fmt;
    s_fmt_t      s_fmt;
    u_fmt_t      u_fmt;
  } instr_u;

  // match patterns where ? bits are don't care
  localparam logic [31:0] pat_lui    = 32'b????????????????????_?????_0110111;
  localparam logic [31:0] pat_auipc  = 32'b????????????????????_?????_0010111;
  localparam logic [31:0] pat_jal    = 32'b????????????????????_?????_1101111;
  localparam logic [31:0] pat_jalr   = 32'b????????????_?????_000_?????_1100111;
  localparam logic [31:0] pat_beq    = 32'b???????_?????_?????_000_?????_1100011;
  localparam logic [31:0] pat_bne    = 32'b???????_?????_?????_001_?????_1100011;
  localparam logic [31:0] pat_blt    = 32'b???????_?????_?????_100_?????_1100011;
  localparam logic [31:0] pat_bge    = 32'b???????_?????_?????_101_?????_1100011;
  localparam logic [31:0] pat_bltu   = 32'b???????_?????_?????_110_?????_1100011;
  localparam logic [31:0] pat_bgeu   = 32'b???????_?????_?????_111_?????_1100011;
  localparam logic [31:0] pat_lb     = 32'b????????????_?????_000_?????_0000011;
  localparam logic [31:0] pat_lh     = 32'b????????????_?????_001_?????_0000011;
  localparam logic [31:0] pat_lw     = 32'b????????????_?????_010_?????_0000011;
  localparam logic [31:0] pat_lbu    = 32'b????????????_?????_100_?????_0000011;
  localparam logic [31:0] pat_lhu    = 32'b????????????_?????_101_?????_0000011;
  localparam logic [31:0] pat_sb     = 32'b???????_?????_?????_000_?????_0100011;
  localparam logic [31:0] pat_sh     = 32'b???????_?????_?????_001_?????_0100011;
  localparam logic [31:0] pat_sw     = 32'b???????_?????_?????_010_?????_0100011;
  localparam logic [31:0] pat_addi   = 32'b????????????_?????_000_?????_0010011;
  localparam logic [31:0] pat_slti   = 32'b????????????_?????_010_?????_0010011;
  localparam logic [31:0] pat_sltiu  = 32'b????????????_?????_011_?????_0010011;
  localparam logic [31:0] pat_xori   = 32'b????????????_?????_100_?????_0010011;
  localparam logic [31:0] pat_ori    = 32'b????????????_?????_110_?????_0010011;
  localparam logic [31:0] pat_andi   = 32'b????????????_?????_111_?????_0010011;
  localparam logic [31:0] pat_slli   = 32'b0000000_?????_?????_001_?????_0010011;
  localparam logic [31:0] pat_srli   = 32'b0000000_?????_?????_101_?????_0010011;
  localparam logic [31:0] pat_srai   = 32'b0100000_?????_?????_101_?????_0010011;
  localparam logic [31:0] pat_add    = 32'b0000000_?????_?????_000_?????_0110011;
  localparam logic [31:0] pat_sub    = 32'b0100000_?????_?????_000_?????_0110011;
  localparam logic [31:0] pat_sll    = 32'b0000000_?????_?????_001_?????_0110011;
  localparam logic [31:0] pat_slt    = 32'b0000000_?????_?????_010_?????_0110011;
  localparam logic [31:0] pat_sltu   = 32'b0000000_?????_?????_011_?????_0110011;
  localparam logic [31:0] pat_xor    = 32'b0000000_?????_?????_100_?????_0110011;
  localparam logic [31:0] pat_srl    = 32'b0000000_?????_?????_101_?????_0110011;
  localparam logic [31:0] pat_sra    = 32'b0100000_?????_?????_101_?????_0110011;
  localparam logic [31:0] pat_or     = 32'b0000000_?????_?????_110_?????_0110011;
  localparam logic [31:0] pat_and    = 32'b0000000_?????_?????_111_?????_0110011;
  localparam logic [31:0] pat_fence  = 32'b????????????_?????_000_?????_0001111;
  localparam logic [31:0] pat_ecall  = 32'b000000000000_00000_000_00000_1110011;
  localparam logic [31:0] pat_ebreak = 32'b000000000001_00000_000_00000_1110011;
  localparam logic [31:0] pat_mret   = 32'b0011000_00010_00000_000_00000_1110011;
  localparam logic [31:0] pat_csrrw  = 32'b????????????_?????_001_?????_1110011;
  localparam logic [31:0] pat_csrrs  = 32'b????????????_?????_010_?????_1110011;
  localparam logic [31:0] pat_csrrc  = 32'b????????????_?????_011_?????_1110011;
  localparam logic [31:0] pat_csrrwi = 32'b????????????_?????_101_?????_1110011;
  localparam logic [31:0] pat_csrrsi = 32'b????????????_?????_110_?????_1110011;
  localparam logic [31:0] pat_csrrci = 32'b????????????_?????_111_?????_1110011;

endpackage

//--- hdl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_cfg.svh"

module reg_file (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic [4:0]          rs1_idx,
  input  wire logic [4:0]          rs2_idx,
  input  wire logic                wb_en,
  input  wire logic [4:0]          wb_rd,
  input  wire logic [`RV_XLEN-1:0] wb_data,
  output logic [`RV_XLEN-1:0]      rs1_data,
  output logic [`RV_XLEN-1:0]      rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

  // x0 is never written so it reads zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_rd != 5'd0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // reads see the value before a same-cycle write
  assign rs1_data = regs[rs1_idx];
  assign rs2_data = regs[rs2_idx];

endmodule
`default_nettype wire

//--- hdl/ex_alu.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_cfg.svh"

module ex_alu
  import rv_pkg::*;
(
  input  wire alu_cmd_e            alu_cmd,
  input  wire logic [`RV_XLEN-1:0] op1,
  input  wire logic [`RV_XLEN-1:0] op2,
  output logic [`RV_XLEN-1:0]      result,
  output logic                     cond
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = op2[4:0];
  assign lt_s  = $signed(op1) < $signed(op2);
  assign lt_u  = op1 < op2;
  assign eq    = op1 == op2;

  always_comb begin
    result = '0;
    cond   = 1'b0;
    case (alu_cmd)
      alu_add:   result = op1 + op2;
      alu_sub:   result = op1 - op2;
      alu_xor:   result = op1 ^ op2;
      alu_or:    result = op1 | op2;
      alu_and:   result = op1 & op2;
      alu_srl:   result = op1 >> shamt;
      alu_sra:   result = $unsigned($signed(op1) >>> shamt);
      alu_sll:   result = op1 << shamt;
      alu_bit_c: result = op1 & ~op2;
      // compares only raise cond
      alu_slt:   cond = lt_s;
      alu_sltu:  cond = lt_u;
      alu_eq:    cond = eq;
      alu_ne:    cond = !eq;
      alu_lt:    cond = lt_s;
      alu_ge:    cond = !lt_s;
      alu_ltu:   cond = lt_u;
      alu_geu:   cond = !lt_u;
      default:   result = '0;
    endcase
    // compare result is 0 or 1
    if (cond) begin
      result[0] = 1'b1;
    end
  end

endmodule
`default_nettype wire

//--- hdl/id_decoder.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_cfg.svh"

module id_decoder
  import rv_pkg::*;
(
  input  wire logic [31:0]         instruction,
  input  wire logic                instr_valid,
  input  wire logic [`RV_XLEN-1:0] pc,
  input  wire logic [`RV_XLEN-1:0] reg_rs1,
  input  wire logic [`RV_XLEN-1:0] reg_rs2,
  input  wire logic [`RV_XLEN-1:0] csr_data,
  output logic [4:0]               rs1_idx,
  output logic [4:0]               rs2_idx,
  output logic [4:0]               rd_idx,
  output alu_cmd_e                 alu_ops,
  output mem_access_e              access_type,
  output wb_sel_e                  wb_sel,
  output pc_sel_e                  pc_sel,
  output logic [`RV_XLEN-1:0]      op1,
  output logic [`RV_XLEN-1:0]      op2,
  output logic [11:0]              csr_rd,
  output logic [`RV_XLEN-1:0]      pc_plus_4,
  output logic [`RV_XLEN-1:0]      pc_branch,
  output logic                     is_jump_instr,
  output logic                     illegal_instr,
  output logic                     env_call,
  output logic                     break_point,
  output logic                     mret_instr
);

  instr_u              instr;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] uimm;

  // empty slots decode as a nop
  assign instr.raw = instr_valid ? instruction : `RV_BUBBLE;

  assign rs1_idx = instr.r_fmt.rs1;
  assign rs2_idx = instr.r_fmt.rs2;
  assign rd_idx  = instr.r_fmt.rd;

  assign imm_i = `RV_XLEN'(signed'(instr.i_fmt.imm12));
  assign imm_s = `RV_XLEN'(signed'({instr.s_fmt.imm_hi, instr.s_fmt.imm_lo}));
  assign imm_b = `RV_XLEN'(signed'({instr.raw[31], instr.raw[7], instr.raw[30:25],
                                    instr.raw[11:8], 1'b0}));
  assign imm_u = {instr.u_fmt.imm20, 12'h000};
  assign imm_j = `RV_XLEN'(signed'({instr.raw[31], instr.raw[19:12], instr.raw[20],
                                    instr.raw[30:21], 1'b0}));
  // csr immediate sits in the rs1 field
  assign uimm  = `RV_XLEN'(instr.r_fmt.rs1);

  always_comb begin
    casez (instr.raw)
      pat_add, pat_addi, pat_auipc, pat_lui, pat_lb, pat_lbu, pat_lh, pat_lhu, pat_lw,
      pat_sb, pat_sh, pat_sw, pat_jal, pat_jalr, pat_csrrw, pat_csrrwi, pat_ecall,
      pat_ebreak, pat_fence:          alu_ops = alu_add;
      pat_sub:                        alu_ops = alu_sub;
      pat_xor, pat_xori, pat_mret:    alu_ops = alu_xor;
      pat_or, pat_ori, pat_csrrs, pat_csrrsi: alu_ops = alu_or;
      pat_and, pat_andi:              alu_ops = alu_and;
      pat_srl, pat_srli:              alu_ops = alu_srl;
      pat_sra, pat_srai:              alu_ops = alu_sra;
      pat_sll, pat_slli:              alu_ops = alu_sll;
      pat_slt, pat_slti:              alu_ops = alu_slt;
      pat_sltu, pat_sltiu:            alu_ops = alu_sltu;
      pat_beq:                        alu_ops = alu_eq;
      pat_bne:                        alu_ops = alu_ne;
      pat_blt:                        alu_ops = alu_lt;
      pat_bge:                        alu_ops = alu_ge;
      pat_bltu:                       alu_ops = alu_ltu;
      pat_bgeu:                       alu_ops = alu_geu;
      pat_csrrc, pat_csrrci:          alu_ops = alu_bit_c;
      default:                        alu_ops = alu_ill;
    endcase

    illegal_instr = instr_valid && (alu_ops == alu_ill);
    env_call      = 1'b0;
    break_point   = 1'b0;
    mret_instr    = 1'b0;
    casez (instr.raw)
      pat_ecall:  env_call = 1'b1;
      pat_ebreak: break_point = 1'b1;
      pat_mret:   mret_instr = 1'b1;
      default: ;
    endcase

    casez (instr.raw)
      pat_lb:  access_type = lb;
      pat_lh:  access_type = lh;
      pat_lw:  access_type = lw;
      pat_lbu: access_type = lbu;
      pat_lhu: access_type = lhu;
      pat_sb:  access_type = sb;
      pat_sh:  access_type = sh;
      pat_sw:  access_type = sw;
      default: access_type = mem_none;
    endcase

    // operand select by opcode where fence and system ops stay zero
    op1 = '0;
    op2 = '0;
    case (instr.r_fmt.opcode)
      7'b0110011, 7'b1100011: begin
        op1 = reg_rs1;
        op2 = reg_rs2;
      end
      7'b0010011, 7'b0000011: begin
        op1 = reg_rs1;
        op2 = imm_i;
      end
      7'b0100011: begin
        op1 = reg_rs1;
        op2 = imm_s;
      end
      7'b0110111: op1 = imm_u;
      7'b0010111: begin
        op1 = imm_u;
        op2 = pc;
      end
      // jal and jalr just need a nonzero marker
      7'b1101111, 7'b1100111: op1 = `RV_XLEN'(1);
      7'b1110011: begin
        casez (instr.raw)
          pat_csrrw:  op1 = reg_rs1;
          pat_csrrwi: op1 = uimm;
          pat_csrrs, pat_csrrc: begin
            op1 = csr_data;
            op2 = reg_rs1;
          end
          pat_csrrsi, pat_csrrci: begin
            op1 = csr_data;
            op2 = uimm;
          end
          pat_mret: begin
            op1 = csr_data;
            op2 = `RV_MRET_MASK;
          end
          default: ;
        endcase
      end
      default: ;
    endcase

    pc_plus_4 = pc + `RV_XLEN'(4);
    case (instr.r_fmt.opcode)
      7'b1100011: pc_branch = pc + imm_b;
      7'b1101111: pc_branch = pc + imm_j;
      // jalr target has bit 0 cleared
      7'b1100111: pc_branch = (reg_rs1 + imm_i) & ~`RV_XLEN'(1);
      default:    pc_branch = '0;
    endcase
    is_jump_instr = (instr.r_fmt.opcode == 7'b1101111) || (instr.r_fmt.opcode == 7'b1100111);

    wb_sel = wb_none;
    case (instr.r_fmt.opcode)
      7'b0110011, 7'b0010011, 7'b0110111, 7'b0010111: wb_sel = ri_type_lui;
      7'b0000011: wb_sel = load;
      7'b1101111, 7'b1100111: wb_sel = jump;
      7'b1110011: begin
        casez (instr.raw)
          pat_csrrw, pat_csrrwi, pat_csrrs, pat_csrrsi, pat_csrrc, pat_csrrci: wb_sel = zicsr;
          default: ;
        endcase
      end
      default: ;
    endcase
    // no write to x0 or for junk words but mret always writes back
    if (rd_idx == 5'd0 || alu_ops == alu_ill) begin
      wb_sel = wb_none;
    end
    if (mret_instr) begin
      wb_sel = wb_mret;
    end

    casez (instr.raw)
      pat_jal, pat_jalr, pat_beq, pat_bne, pat_blt, pat_bge, pat_bltu, pat_bgeu:
        pc_sel = rv_pkg::pc_branch;
      pat_mret: pc_sel = pc_mret;
      default:  pc_sel = pc_next;
    endcase

    casez (instr.raw)
      pat_csrrw, pat_csrrwi, pat_csrrs, pat_csrrsi, pat_csrrc, pat_csrrci:
        csr_rd = instr.i_fmt.imm12;
      pat_mret: csr_rd = `RV_MRET_CSR;
      default:  csr_rd = 12'h000;
    endcase
  end

endmodule
`default_nettype wire

//--- hdl/id_ex_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_cfg.svh"

module id_ex_stage
  import rv_pkg::*;
(
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic [31:0]         instruction,
  input  wire logic                instr_valid,
  input  wire logic [`RV_XLEN-1:0] pc,
  input  wire logic [`RV_XLEN-1:0] csr_data,
  output logic [11:0]              csr_rd,
  input  wire logic                wb_en,
  input  wire logic [4:0]          wb_rd,
  input  wire logic [`RV_XLEN-1:0] wb_data,
  output logic                     ex_valid,
  output logic [`RV_XLEN-1:0]      alu_result,
  output wb_sel_e                  wb_sel,
  output pc_sel_e                  pc_sel,
  output mem_access_e              access_type,
  output logic [`RV_XLEN-1:0]      wb_value,
  output logic                     branch_taken,
  output logic [`RV_XLEN-1:0]      branch_target,
  output logic [11:0]              csr_addr,
  output logic [`RV_XLEN-1:0]      store_data,
  output logic                     illegal_instr,
  output logic                     env_call,
  output logic                     break_point,
  output logic                     mret_instr
);

  logic [4:0]          rs1_idx;
  logic [4:0]          rs2_idx;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;

  alu_cmd_e            id_alu_ops;
  mem_access_e         id_access;
  wb_sel_e             id_wb_sel;
  pc_sel_e             id_pc_sel;
  logic [`RV_XLEN-1:0] id_op1;
  logic [`RV_XLEN-1:0] id_op2;
  logic [`RV_XLEN-1:0] id_pc_plus_4;
  logic [`RV_XLEN-1:0] id_pc_branch;
  logic                id_is_jump;
  logic                id_illegal;
  logic                id_ecall;
  logic                id_ebreak;
  logic                id_mret;

  // ID/EX register
  logic                idex_valid;
  alu_cmd_e            idex_alu_cmd;
  mem_access_e         idex_access;
  wb_sel_e             idex_wb_sel;
  pc_sel_e             idex_pc_sel;
  logic                idex_is_jump;
  logic                idex_illegal;
  logic                idex_ecall;
  logic                idex_ebreak;
  logic                idex_mret;
  logic [`RV_XLEN-1:0] idex_op1;
  logic [`RV_XLEN-1:0] idex_op2;
  logic [`RV_XLEN-1:0] idex_pc_plus_4;
  logic [`RV_XLEN-1:0] idex_pc_branch;
  logic [`RV_XLEN-1:0] idex_csr_data;
  logic [`RV_XLEN-1:0] idex_store;
  logic [11:0]         idex_csr_addr;

  logic [`RV_XLEN-1:0] alu_res;
  logic                alu_cond;
  logic [`RV_XLEN-1:0] ex_wb_value;
  logic                ex_taken;

  id_decoder u_decoder (
    .instruction   (instruction),
    .instr_valid   (instr_valid),
    .pc            (pc),
    .reg_rs1       (rs1_data),
    .reg_rs2       (rs2_data),
    .csr_data      (csr_data),
    .rs1_idx       (rs1_idx),
    .rs2_idx       (rs2_idx),
    .rd_idx        (),
    .alu_ops       (id_alu_ops),
    .access_type   (id_access),
    .wb_sel        (id_wb_sel),
    .pc_sel        (id_pc_sel),
    .op1           (id_op1),
    .op2           (id_op2),
    .csr_rd        (csr_rd),
    .pc_plus_4     (id_pc_plus_4),
    .pc_branch     (id_pc_branch),
    .is_jump_instr (id_is_jump),
    .illegal_instr (id_illegal),
    .env_call      (id_ecall),
    .break_point   (id_ebreak),
    .mret_instr    (id_mret)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .wb_en    (wb_en),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idex_valid   <= 1'b0;
      idex_alu_cmd <= alu_add;
      idex_access  <= mem_none;
      idex_wb_sel  <= wb_none;
      idex_pc_sel  <= pc_next;
      idex_is_jump <= 1'b0;
      idex_illegal <= 1'b0;
      idex_ecall   <= 1'b0;
      idex_ebreak  <= 1'b0;
      idex_mret    <= 1'b0;
    end else begin
      idex_valid   <= instr_valid;
      idex_alu_cmd <= id_alu_ops;
      idex_access  <= id_access;
      idex_wb_sel  <= id_wb_sel;
      idex_pc_sel  <= id_pc_sel;
      idex_is_jump <= id_is_jump;
      idex_illegal <= id_illegal;
      idex_ecall   <= id_ecall;
      idex_ebreak  <= id_ebreak;
      idex_mret    <= id_mret;
    end
  end

  // operands, targets and the csr value read this cycle
  always_ff @(posedge clk) begin
    idex_op1       <= id_op1;
    idex_op2       <= id_op2;
    idex_pc_plus_4 <= id_pc_plus_4;
    idex_pc_branch <= id_pc_branch;
    idex_csr_data  <= csr_data;
    idex_store     <= rs2_data;
    idex_csr_addr  <= csr_rd;
  end

  ex_alu u_alu (
    .alu_cmd (idex_alu_cmd),
    .op1     (idex_op1),
    .op2     (idex_op2),
    .result  (alu_res),
    .cond    (alu_cond)
  );

  assign ex_taken = (idex_pc_sel == pc_branch) && (idex_is_jump || alu_cond);

  always_comb begin
    case (idex_wb_sel)
      jump:           ex_wb_value = idex_pc_plus_4;
      // old csr value goes to rd
      zicsr, wb_mret: ex_wb_value = idex_csr_data;
      default:        ex_wb_value = alu_res;
    endcase
  end

  // EX output register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid      <= 1'b0;
      wb_sel        <= wb_none;
      pc_sel        <= pc_next;
      access_type   <= mem_none;
      branch_taken  <= 1'b0;
      illegal_instr <= 1'b0;
      env_call      <= 1'b0;
      break_point   <= 1'b0;
      mret_instr    <= 1'b0;
    end else begin
      ex_valid      <= idex_valid;
      wb_sel        <= idex_wb_sel;
      pc_sel        <= idex_pc_sel;
      access_type   <= idex_access;
      branch_taken  <= ex_taken;
      illegal_instr <= idex_illegal;
      env_call      <= idex_ecall;
      break_point   <= idex_ebreak;
      mret_instr    <= idex_mret;
    end
  end

  always_ff @(posedge clk) begin
    alu_result    <= alu_res;
    wb_value      <= ex_wb_value;
    branch_target <= (idex_pc_sel == pc_mret) ? idex_csr_data : idex_pc_branch;
    csr_addr      <= idex_csr_addr;
    store_data    <= idex_store;
  end

endmodule
`default_nettype wire

//--- dv/id_ex_assertions.sv
`timescale 1ns/10ps

module id_ex_assertions
  import rv_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input logic    ex_valid,
  input logic    illegal_instr,
  input logic    env_call,
  input logic    break_point,
  input logic    mret_instr,
  input pc_sel_e pc_sel
);

  // number of failed assertions
  int unsigned fail_count = 0;

  a_valid_in_reset: assert property (@(posedge clk) !rst_n |-> !ex_valid)
    else begin
      $error("ex_valid high during reset");
      fail_count++;
    end

  // the exception flags are exclusive
  a_one_flag: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({illegal_instr, env_call, break_point, mret_instr}))
    else begin
      $error("more than one flag high");
      fail_count++;
    end

  a_illegal_valid: assert property (@(posedge clk) disable iff (!rst_n)
    illegal_instr |-> ex_valid)
    else begin
      $error("illegal_instr without ex_valid");
      fail_count++;
    end

  a_mret_sel: assert property (@(posedge clk) disable iff (!rst_n)
    (pc_sel == pc_mret) |-> mret_instr)
    else begin
      $error("pc_mret without mret_instr");
      fail_count++;
    end

endmodule

bind id_ex_stage id_ex_assertions u_assertions (.*);

//--- dv/tb_id_ex.sv
`timescale 1ns/10ps
`include "rv_cfg.svh"

module tb_id_ex
  import rv_pkg::*;
;

  localparam int NUM_INSTR = 400;
  localparam int MAX_CYCLES = NUM_INSTR + 8 + 20;

  typedef struct packed {
    logic        valid;
    logic        chk_res;
    logic [31:0] res;
    wb_sel_e     wb;
    pc_sel_e     ps;
    mem_access_e acc;
    logic [31:0] wbv;
    logic        taken;
    logic [31:0] target;
    logic [11:0] csr_addr;
    logic [31:0] store;
    logic        ill;
    logic        ecall;
    logic        ebrk;
    logic        mret;
  } exp_t;

  logic clk;
  logic rst_n;
  logic [31:0] instruction;
  logic instr_valid;
  logic [31:0] pc;
  logic [31:0] csr_data;
  logic [11:0] csr_rd;
  logic wb_en;
  logic [4:0] wb_rd;
  logic [31:0] wb_data;
  logic ex_valid;
  logic [31:0] alu_result;
  wb_sel_e wb_sel;
  pc_sel_e pc_sel;
  mem_access_e access_type;
  logic [31:0] wb_value;
  logic branch_taken;
  logic [31:0] branch_target;
  logic [11:0] csr_addr;
  logic [31:0] store_data;
  logic illegal_instr;
  logic env_call;
  logic break_point;
  logic mret_instr;

  logic [31:0] rng_state;
  logic [31:0] regs_model [32];
  exp_t exp_q [$];
  int cycles;

  id_ex_stage uut (.*);

  always #10 clk = ~clk;

  // model csr contents derived from every address bit
  function automatic logic [31:0] csr_value(logic [11:0] a);
    return {~a[7:0], a, a ^ 12'h5a3};
  endfunction

  assign csr_data = csr_value(csr_rd);

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // rv32i integer op by funct3 where alt picks sub or sra
  function automatic logic [31:0] int_op(logic [2:0] f3, logic alt, logic [31:0] a,
                                         logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'd0, $signed(a) < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] build_word(int kind, logic [31:0] r, logic [31:0] s);
    logic [31:0] w;
    logic [2:0] f3;
    w = r;
    f3 = s[2:0];
    case (kind)
      0: begin
        w[6:0] = 7'b0110011;
        w[14:12] = f3;
        w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && s[3]) ? 7'h20 : 7'h00;
      end
      1: begin
        w[6:0] = 7'b0010011;
        w[14:12] = f3;
        if (f3 == 3'd1) w[31:25] = 7'h00;
        if (f3 == 3'd5) w[31:25] = s[3] ? 7'h20 : 7'h00;
      end
      2: w[6:0] = s[0] ? 7'b0110111 : 7'b0010111;
      3: begin
        f3 = 3'(s % 5);
        if (f3 > 3'd2) f3 = f3 + 3'd1;
        w[14:12] = f3;
        w[6:0] = 7'b0000011;
      end
      4: begin
        w[14:12] = 3'(s % 3);
        w[6:0] = 7'b0100011;
      end
      5: begin
        f3 = 3'(s % 6);
        if (f3 >= 3'd2) f3 = f3 + 3'd2;
        w[14:12] = f3;
        w[6:0] = 7'b1100011;
      end
      6, 7: begin
        w[6:0] = (kind == 6) ? 7'b1101111 : 7'b1100111;
        if (kind == 7) w[14:12] = 3'd0;
        if (w[11:7] == 5'd0) w[11:7] = 5'd1;
      end
      8: begin
        f3 = 3'(s % 6) + 3'd1;
        if (f3 >= 3'd4) f3 = f3 + 3'd1;
        w[14:12] = f3;
        w[6:0] = 7'b1110011;
      end
      9: w = (s % 3 == 0) ? pat_ecall : (s % 3 == 1) ? pat_ebreak : pat_mret;
      default: w[6:0] = 7'h7f;
    endcase
    return w;
  endfunction

  // expected outputs straight from the rv32i and zicsr rules
  function automatic exp_t predict(logic [31:0] word, logic v, logic [31:0] ipc);
    exp_t e;
    logic [31:0] w;
    logic [2:0] f3;
    logic [31:0] rs1v;
    logic [31:0] immi;
    logic [31:0] csr;
    logic [31:0] src;
    logic c;
    w = v ? word : `RV_BUBBLE;
    f3 = w[14:12];
    rs1v = regs_model[w[19:15]];
    immi = {{20{w[31]}}, w[31:20]};
    csr = '0;
    e = '0;
    e.valid = v;
    e.chk_res = 1'b1;
    e.wb = wb_none;
    e.ps = pc_next;
    e.acc = mem_none;
    e.store = regs_model[w[24:20]];
    case (w[6:0])
      7'b0110011: begin
        e.res = int_op(f3, w[30], rs1v, regs_model[w[24:20]]);
        e.wb = ri_type_lui;
      end
      7'b0010011: begin
        e.res = int_op(f3, w[30] && f3 == 3'd5, rs1v, immi);
        e.wb = ri_type_lui;
      end
      7'b0110111, 7'b0010111: begin
        e.res = {w[31:12], 12'h000} + (w[5] ? 32'd0 : ipc);
        e.wb = ri_type_lui;
      end
      7'b0000011: begin
        e.res = rs1v + immi;
        e.wb = load;
        e.acc = (f3 == 0) ? lb : (f3 == 1) ? lh : (f3 == 2) ? lw : (f3 == 4) ? lbu : lhu;
      end
      7'b0100011: begin
        e.res = rs1v + {{20{w[31]}}, w[31:25], w[11:7]};
        e.acc = (f3 == 0) ? sb : (f3 == 1) ? sh : sw;
      end
      7'b1100011: begin
        case (f3)
          3'd0: c = rs1v == e.store;
          3'd1: c = rs1v != e.store;
          3'd4: c = $signed(rs1v) < $signed(e.store);
          3'd5: c = $signed(rs1v) >= $signed(e.store);
          3'd6: c = rs1v < e.store;
          default: c = rs1v >= e.store;
        endcase
        e.res = {31'd0, c};
        e.taken = c;
        e.ps = pc_branch;
        e.target = ipc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      end
      7'b1101111, 7'b1100111: begin
        e.chk_res = 1'b0;
        e.wb = jump;
        e.taken = 1'b1;
        e.ps = pc_branch;
        if (w[3]) begin
          e.target = ipc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end else begin
          e.target = (rs1v + immi) & ~32'd1;
        end
      end
      7'b1110011: begin
        if (f3 != 3'd0) begin
          csr = csr_value(w[31:20]);
          src = f3[2] ? {27'd0, w[19:15]} : rs1v;
          e.res = (f3[1:0] == 2'd1) ? src : (f3[1:0] == 2'd2) ? csr | src : csr & ~src;
          e.wb = zicsr;
          e.csr_addr = w[31:20];
        end else if (w == pat_mret) begin
          csr = csr_value(12'h300);
          e.res = csr ^ 32'h88;
          e.wb = wb_mret;
          e.ps = pc_mret;
          e.target = csr;
          e.csr_addr = 12'h300;
          e.mret = 1'b1;
        end else begin
          e.ecall = (w == pat_ecall);
          e.ebrk = (w == pat_ebreak);
        end
      end
      default: e.ill = v;
    endcase
    if (w[11:7] == 5'd0 && e.wb != wb_mret) e.wb = wb_none;
    if (e.wb == jump) e.wbv = ipc + 32'd4;
    else if (e.wb == zicsr || e.wb == wb_mret) e.wbv = csr;
    else e.wbv = e.res;
    return e;
  endfunction

  task automatic report_error(string name, logic [31:0] got, logic [31:0] exp);
    $display("Error: time %0t, %s got %h expected %h", $time, name, got, exp);
    $display("tests failed");
    $fatal(1, "stopping at the first mismatch");
  endtask

  task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) report_error(name, got, exp);
  endtask

  task automatic check_wb_sel(wb_sel_e got, wb_sel_e exp);
    if (got !== exp) report_error("wb_sel", 32'(got), 32'(exp));
  endtask

  task automatic check_pc_sel(pc_sel_e got, pc_sel_e exp);
    if (got !== exp) report_error("pc_sel", 32'(got), 32'(exp));
  endtask

  task automatic check_access(mem_access_e got, mem_access_e exp);
    if (got !== exp) report_error("access_type", 32'(got), 32'(exp));
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) report_error(name, 32'(got), 32'(exp));
  endtask

  task automatic compare_outputs(exp_t e);
    check_flag("ex_valid", ex_valid, e.valid);
    if (e.chk_res) check_word("alu_result", alu_result, e.res);
    check_wb_sel(wb_sel, e.wb);
    check_pc_sel(pc_sel, e.ps);
    check_access(access_type, e.acc);
    check_word("wb_value", wb_value, e.wbv);
    check_flag("branch_taken", branch_taken, e.taken);
    check_word("branch_target", branch_target, e.target);
    check_word("csr_addr", 32'(csr_addr), 32'(e.csr_addr));
    check_word("store_data", store_data, e.store);
    check_flag("illegal_instr", illegal_instr, e.ill);
    check_flag("env_call", env_call, e.ecall);
    check_flag("break_point", break_point, e.ebrk);
    check_flag("mret_instr", mret_instr, e.mret);
  endtask

  // drive one slot, predict it, then commit the write port to the model
  task automatic issue_slot(logic active);
    logic [31:0] r;
    logic [31:0] s;
    r = next_rand();
    s = next_rand();
    instr_valid = active && (r[2:0] != 3'd0);
    instruction = build_word(int'(s % 11), next_rand(), next_rand());
    pc = next_rand() & ~32'd3;
    wb_en = active && r[3];
    wb_rd = r[8:4];
    wb_data = r[9] ? next_rand() : (next_rand() & 32'd3);
    exp_q.push_back(predict(instruction, instr_valid, pc));
    if (wb_en && wb_rd != 5'd0) regs_model[wb_rd] = wb_data;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout, the run went past its cycle limit");
      $display("tests failed");
      $fatal(1, "cycle limit reached");
    end
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    instruction = '0;
    instr_valid = 1'b0;
    pc = '0;
    wb_en = 1'b0;
    wb_rd = '0;
    wb_data = '0;
    cycles = 0;
    rng_state = 32'd7978;
    for (int i = 0; i < 32; i++) regs_model[i] = '0;
    repeat (8) @(posedge clk);
    #2 rst_n = 1'b1;
    // two trailing idle slots flush the pipe
    for (int n = 0; n < NUM_INSTR + 2; n++) begin
      @(posedge clk);
      #1;
      if (exp_q.size() == 2) compare_outputs(exp_q.pop_front());
      #1;
      issue_slot(n < NUM_INSTR);
    end
    if (uut.u_assertions.fail_count != 0) begin
      $display("%0d assertion checks failed during the run", uut.u_assertions.fail_count);
      $display("tests failed");
      $fatal(1, "assertion failures");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

//--- build.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/reg_file.sv
hdl/ex_alu.sv
hdl/id_decoder.sv
hdl/id_ex_stage.sv
dv/id_ex_assertions.sv
dv/tb_id_ex.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_id_ex
FILELIST  ?= build.f
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
